// ==== armController.sv ====
`include "armCtrlSettings.svh"

module armController (
  input  logic                  clk,
  input  logic                  arstN,
  input  armIsaPkg::instrU      instrD,
  input  armPipePkg::flagsT     aluFlagsE,
  input  logic [`ARM_XLEN-1:0]  aluResultE,
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushE,
  input  logic                  flushM,
  input  logic                  flushW,
  output armPipePkg::decOutT    decOut,
  output armIsaPkg::aluOpT      aluControlE,
  output logic                  aluSrcE,
  output logic                  branchTakenE,
  output logic                  memReadE,
  output logic                  memWriteM,
  output logic                  memReadM,
  output logic                  regWriteM,
  output logic [`ARM_BYTES-1:0] byteMaskM,
  output logic                  regWriteW,
  output logic                  memReadW,
  output logic                  pcSrcW,
  output armPipePkg::flagsT     flags,
  output logic                  pcWrPendingF
);
  import armPipePkg::*;

  exCtrlT  exCtrl;
  memCtrlT memCtrlM;
  wbCtrlT  wbCtrlM;
  logic    pcSrcD;
  logic    wbSetFlagsW;
  flagsT   wbFlagsW;

  decodeStage uDecode (.clk, .arstN, .instrD, .stallE, .flushE, .decOut, .exCtrl, .pcSrcD);

  executeStage uExecute (
    .clk, .arstN, .exCtrl, .aluFlagsE, .aluResultE,
    .committedFlags (flags),
    .wbSetFlagsW, .wbFlagsW, .stallM, .flushM,
    .aluControlE, .aluSrcE, .branchTakenE, .memReadE, .memCtrlM, .wbCtrlM
  );

  writebackStage uWriteback (
    .clk, .arstN, .wbCtrlM, .stallW, .flushW,
    .regWriteW, .memReadW, .pcSrcW, .wbSetFlagsW, .wbFlagsW, .flags
  );

  assign memWriteM = memCtrlM.memWrite;
  assign memReadM  = memCtrlM.memRead;
  assign regWriteM = memCtrlM.regWrite;
  assign byteMaskM = memCtrlM.byteMask;

  // PC write in flight from D, E or M, fetch must wait
  assign pcWrPendingF = pcSrcD | exCtrl.pcSrc | memCtrlM.pcSrc;

endmodule

// ==== armCtrlGolden.txt ====
// instr aluFlags aluResult stall(WME) flush(WME) | decOut aluCtlE eBits(src,br,rd)
// mBits(wr,rd,reg) byteMask wBits(reg,rd,pc) flagsAfter pcWrPendingF
E2812005 0 00000000 0 0 01 4 4 1 0 4 0 0
E0913002 6 00000000 0 0 00 4 0 1 0 4 6 0
08000010 0 00000000 0 0 0D 4 6 0 0 1 6 1
18000010 0 00000000 0 0 0D 4 4 0 0 0 6 1
22814001 0 00000000 0 0 01 4 4 1 0 4 6 1
42815001 0 00000000 0 0 01 4 4 0 0 0 6 0
E1510002 8 00000000 0 0 00 A 0 0 0 0 8 0
A2816001 0 00000000 0 0 01 4 4 0 0 0 8 0
B2817001 0 00000000 0 0 01 4 4 1 0 4 8 0
01510002 4 00000000 0 0 00 A 0 0 0 0 8 0
C2818001 0 00000000 0 0 01 4 4 0 0 0 8 0
E2919001 9 00000000 0 0 01 4 4 1 0 4 9 0
C281A001 0 00000000 0 0 01 4 4 1 0 4 9 0
E591B004 0 00000000 0 0 03 4 5 3 0 6 9 0
E511C004 0 00000000 0 0 03 2 5 3 0 6 9 0
E581D000 0 00000100 0 0 13 4 4 4 F 0 9 0
E5C1D000 0 00000100 0 0 13 4 4 4 1 0 9 0
E5C1D000 0 00000101 0 0 13 4 4 4 2 0 9 0
E5C1D000 0 00000102 0 0 13 4 4 4 4 0 9 0
E541D000 0 00000103 0 0 13 2 4 4 8 0 9 0
5581D000 0 00000100 0 0 13 4 4 0 0 0 9 0
E8000010 0 00000000 0 0 0D 4 6 0 0 1 9 1
E2812005 0 00000000 0 1 01 0 0 0 0 0 9 1
E2919001 F 00000000 7 0 01 0 0 0 0 0 9 1
E2919001 2 00000000 0 0 01 4 4 1 0 4 2 1
22814001 0 00000000 0 0 01 4 4 1 0 4 2 0
EC000000 0 00000000 0 0 00 4 0 0 0 0 2 0
EC000000 0 00000000 0 0 00 4 0 0 0 0 2 0
EC000000 0 00000000 0 0 00 4 0 0 0 0 2 0
EC000000 0 00000000 0 0 00 4 0 0 0 0 2 0

// ==== armCtrlSettings.svh ====
`ifndef ARM_CTRL_SETTINGS_SVH
`define ARM_CTRL_SETTINGS_SVH

// ==================================================
// Word and lane widths
// ==================================================
// Instruction and data word
`define ARM_XLEN   32
// Flags in N Z C V order
`define ARM_NFLAGS 4
// Byte lanes per word and the address bits that pick one
`define ARM_BYTES  4
`define ARM_BOFF_W 2

// ==================================================
// Instruction fields
// ==================================================
`define ARM_REG_W  4
`define ARM_OP2_W  12
`define ARM_PC_IDX 15

`endif

// ==== armIsaPkg.sv ====
`include "armCtrlSettings.svh"

package armIsaPkg;

  // Condition field, odd codes invert the even one below
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condT;

  // Data-processing opcodes, bits [24:21]
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
  } aluOpT;

  // Bits [27:26]
  typedef enum logic [1:0] {
    DATA, MEM, BRANCH, OTHER
  } instrClassT;

  // ==================================================
  // Instruction layouts
  // ==================================================
  typedef struct packed {
    condT                  cond;
    instrClassT            instrClass;
    logic                  immBit;     // Operand2 is a rotated immediate
    aluOpT                 opcode;
    logic                  s;          // Set flags
    logic [`ARM_REG_W-1:0] rn;
    logic [`ARM_REG_W-1:0] rd;
    logic [`ARM_OP2_W-1:0] operand2;
  } dpFormatT;

  typedef struct packed {
    condT                  cond;
    instrClassT            instrClass;
    logic                  regOff;     // Offset is a register
    logic                  p;          // Pre-index
    logic                  u;          // Add offset when set
    logic                  b;          // Byte access
    logic                  w;          // Write back base
    logic                  l;          // Load when set, store when clear
    logic [`ARM_REG_W-1:0] rn;
    logic [`ARM_REG_W-1:0] rd;
    logic [`ARM_OP2_W-1:0] offset;
  } memFormatT;

  // One Decode word, two readings; branch needs only cond and class
  typedef union packed {
    dpFormatT  dp;
    memFormatT mem;
  } instrU;

endpackage

// ==== armPipePkg.sv ====
`include "armCtrlSettings.svh"

package armPipePkg;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // D to E, ungated
  typedef struct packed {
    armIsaPkg::condT  cond;
    armIsaPkg::aluOpT aluControl;
    logic             aluSrc;
    logic             flagWrite;
    logic             branch;
    logic             memWrite;
    logic             memRead;
    logic             regWrite;
    logic             pcSrc;
    logic             isByte;
  } exCtrlT;

  // E to M, already gated by the condition
  typedef struct packed {
    logic                  memWrite;
    logic                  memRead;
    logic                  regWrite;
    logic                  pcSrc;
    logic [`ARM_BYTES-1:0] byteMask;
  } memCtrlT;

  // M to W
  typedef struct packed {
    logic  memRead;
    logic  regWrite;
    logic  pcSrc;
    logic  setFlags;
    flagsT flagsNext;
  } wbCtrlT;

  // Decode selects straight to the datapath
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
  } decOutT;

endpackage

// ==== condUnit.sv ====
module condUnit (
  input  armIsaPkg::condT   cond,
  input  armPipePkg::flagsT flags,
  input  armPipePkg::flagsT aluFlags,
  input  logic              flagWrite,
  input  armIsaPkg::aluOpT  aluControl,
  output logic              condEx,
  output armPipePkg::flagsT flagsNext,
  output logic              noRegWrite
);
  import armIsaPkg::*;

  logic baseHit;   // Result of the even code of each pair

  // ==================================================
  // Condition table
  // ==================================================
  always_comb begin
    case (cond)
      EQ, NE:  baseHit = flags.z;
      CS, CC:  baseHit = flags.c;
      MI, PL:  baseHit = flags.n;
      VS, VC:  baseHit = flags.v;
      HI, LS:  baseHit = flags.c & ~flags.z;
      GE, LT:  baseHit = (flags.n == flags.v);
      GT, LE:  baseHit = ~flags.z & (flags.n == flags.v);
      default: baseHit = 1'b1;                       // AL, NV inverts it
    endcase
    condEx = baseHit ^ cond[0];                      // Odd code is the complement
  end

  // New flags only from an executed S instruction
  assign flagsNext = (flagWrite && condEx) ? aluFlags : flags;

  // Compare and test write only flags
  always_comb begin
    case (aluControl)
      TST, TEQ, CMP, CMN: noRegWrite = 1'b1;
      default:            noRegWrite = 1'b0;
    endcase
  end

endmodule

// ==== decodeStage.sv ====
`include "armCtrlSettings.svh"

module decodeStage (
  input  logic               clk,
  input  logic               arstN,
  input  armIsaPkg::instrU   instrD,
  input  logic               stallE,
  input  logic               flushE,
  output armPipePkg::decOutT decOut,
  output armPipePkg::exCtrlT exCtrl,
  output logic               pcSrcD
);
  import armIsaPkg::*;
  import armPipePkg::*;

  exCtrlT exCtrlD;

  // ==================================================
  // Decode
  // ==================================================
  always_comb begin
    decOut             = '0;
    exCtrlD            = '0;
    exCtrlD.cond       = instrD.dp.cond;
    exCtrlD.aluControl = ADD;                        // Branch target and other forms
    case (instrD.dp.instrClass)
      DATA: begin
        decOut.aluSrc      = instrD.dp.immBit;       // Immediate or register operand2
        exCtrlD.aluControl = instrD.dp.opcode;
        exCtrlD.flagWrite  = instrD.dp.s;
        exCtrlD.regWrite   = 1'b1;
      end
      MEM: begin
        // Store reads rd as the second source
        decOut.regSrc      = instrD.mem.l ? 2'b00 : 2'b10;
        decOut.immSrc      = 2'b01;                  // 12-bit offset
        decOut.aluSrc      = ~instrD.mem.regOff;
        exCtrlD.aluControl = instrD.mem.u ? ADD : SUB;
        exCtrlD.memRead    = instrD.mem.l;
        exCtrlD.regWrite   = instrD.mem.l;
        exCtrlD.memWrite   = ~instrD.mem.l;
        exCtrlD.isByte     = instrD.mem.b;
      end
      BRANCH: begin
        decOut.regSrc  = 2'b01;                      // rn is the PC
        decOut.immSrc  = 2'b10;                      // 24-bit word offset
        decOut.aluSrc  = 1'b1;
        exCtrlD.branch = 1'b1;
      end
      default: ;                                     // Unsupported, no controls
    endcase
    exCtrlD.aluSrc = decOut.aluSrc;
    // PC changes on a branch or on a write to r15
    exCtrlD.pcSrc = (exCtrlD.regWrite && instrD.dp.rd == `ARM_REG_W'(`ARM_PC_IDX))
                    || exCtrlD.branch;
  end

  assign pcSrcD = exCtrlD.pcSrc;

  // ==================================================
  // D to E register
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exCtrl <= '0;
    end else if (!stallE) begin
      if (flushE) exCtrl <= '0;                      // Bubble
      else        exCtrl <= exCtrlD;
    end
  end

  // A data-processing word reaches E without any memory access pair
  assert property (@(posedge clk) disable iff (!arstN)
    (instrD.dp.instrClass == DATA && !stallE && !flushE)
    |=> !(exCtrl.memRead && exCtrl.memWrite));

endmodule

// ==== executeStage.sv ====
`include "armCtrlSettings.svh"

module executeStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  armPipePkg::exCtrlT   exCtrl,
  input  armPipePkg::flagsT    aluFlagsE,
  input  logic [`ARM_XLEN-1:0] aluResultE,
  input  armPipePkg::flagsT    committedFlags,
  input  logic                 wbSetFlagsW,
  input  armPipePkg::flagsT    wbFlagsW,
  input  logic                 stallM,
  input  logic                 flushM,
  output armIsaPkg::aluOpT     aluControlE,
  output logic                 aluSrcE,
  output logic                 branchTakenE,
  output logic                 memReadE,
  output armPipePkg::memCtrlT  memCtrlM,
  output armPipePkg::wbCtrlT   wbCtrlM
);
  import armPipePkg::*;

  logic    condEx;
  logic    noRegWrite;
  flagsT   flagsE;
  flagsT   flagsNextE;
  memCtrlT memCtrlE;
  wbCtrlT  wbCtrlE;

  // Newest pending flags win, M before W before the status register
  always_comb begin
    if (wbCtrlM.setFlags) flagsE = wbCtrlM.flagsNext;
    else if (wbSetFlagsW) flagsE = wbFlagsW;
    else                  flagsE = committedFlags;
  end

  condUnit uCond (
    .cond       (exCtrl.cond),
    .flags      (flagsE),
    .aluFlags   (aluFlagsE),
    .flagWrite  (exCtrl.flagWrite),
    .aluControl (exCtrl.aluControl),
    .condEx     (condEx),
    .flagsNext  (flagsNextE),
    .noRegWrite (noRegWrite)
  );

  // ==================================================
  // Condition gating
  // ==================================================
  always_comb begin
    memCtrlE.memWrite = exCtrl.memWrite & condEx;
    memCtrlE.memRead  = exCtrl.memRead & condEx;     // No stray read, could fault
    memCtrlE.regWrite = exCtrl.regWrite & condEx & ~noRegWrite;
    memCtrlE.pcSrc    = exCtrl.pcSrc & condEx;
    memCtrlE.byteMask = '0;
    if (memCtrlE.memWrite) begin
      if (exCtrl.isByte) memCtrlE.byteMask[aluResultE[`ARM_BOFF_W-1:0]] = 1'b1;
      else               memCtrlE.byteMask = '1;     // Full word
    end
    wbCtrlE.memRead   = memCtrlE.memRead;
    wbCtrlE.regWrite  = memCtrlE.regWrite;
    wbCtrlE.pcSrc     = memCtrlE.pcSrc;
    wbCtrlE.setFlags  = exCtrl.flagWrite & condEx;
    wbCtrlE.flagsNext = flagsNextE;
  end

  assign aluControlE  = exCtrl.aluControl;
  assign aluSrcE      = exCtrl.aluSrc;
  assign branchTakenE = exCtrl.branch & condEx;
  assign memReadE     = memCtrlE.memRead;

  // E to M register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlM <= '0;
      wbCtrlM  <= '0;
    end else if (!stallM) begin
      if (flushM) begin
        memCtrlM <= '0;
        wbCtrlM  <= '0;
      end else begin
        memCtrlM <= memCtrlE;
        wbCtrlM  <= wbCtrlE;
      end
    end
  end

  // Held or flushed, M never carries lanes without a store
  assert property (@(posedge clk) disable iff (!arstN)
    !memCtrlM.memWrite |-> (memCtrlM.byteMask == '0));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tbArmController -o simArmCtrl

out=$(./obj_dir/simArmCtrl)
echo "$out"

if grep -qx "TEST PASS" <<< "$out"; then
  exit 0
fi
exit 1

// ==== src.f ====
+incdir+.
armIsaPkg.sv
armPipePkg.sv
condUnit.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
armController.sv
tbArmController.sv

// ==== tbArmController.sv ====
`include "armCtrlSettings.svh"

module tbArmController;
  timeunit 1ns;
  timeprecision 100ps;

  import armIsaPkg::*;
  import armPipePkg::*;

  localparam int MaxSlots  = 64;     // Pipeline steps that can hold expectations
  localparam int MaxCycles = 400;    // Watchdog limit in clock cycles

  logic                  clk;
  logic                  arstN;
  instrU                 instrD;
  flagsT                 aluFlagsE;
  logic [`ARM_XLEN-1:0]  aluResultE;
  logic                  stallE;
  logic                  stallM;
  logic                  stallW;
  logic                  flushE;
  logic                  flushM;
  logic                  flushW;
  decOutT                decOut;
  aluOpT                 aluControlE;
  logic                  aluSrcE;
  logic                  branchTakenE;
  logic                  memReadE;
  logic                  memWriteM;
  logic                  memReadM;
  logic                  regWriteM;
  logic [`ARM_BYTES-1:0] byteMaskM;
  logic                  regWriteW;
  logic                  memReadW;
  logic                  pcSrcW;
  flagsT                 flags;
  logic                  pcWrPendingF;

  // Expectations indexed by pipeline step
  logic [3:0] expAluCtl [MaxSlots];
  logic [2:0] expEBits  [MaxSlots];  // aluSrc, branchTaken, memRead
  logic [2:0] expMBits  [MaxSlots];  // memWrite, memRead, regWrite
  logic [3:0] expMask   [MaxSlots];
  logic [2:0] expWBits  [MaxSlots];  // regWrite, memRead, pcSrc
  logic [3:0] expFlags  [MaxSlots];

  int errCount;
  int checkCount;

  armController UUT (
    .clk, .arstN, .instrD, .aluFlagsE, .aluResultE,
    .stallE, .stallM, .stallW, .flushE, .flushM, .flushW,
    .decOut, .aluControlE, .aluSrcE, .branchTakenE, .memReadE,
    .memWriteM, .memReadM, .regWriteM, .byteMaskM,
    .regWriteW, .memReadW, .pcSrcW, .flags, .pcWrPendingF
  );

  // ==================================================
  // Clock and watchdog
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;           // 10 ns period
  end

  initial begin
    for (int c = 0; c < MaxCycles; c++) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", MaxCycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic checkField(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // ==================================================
  // Golden file replay
  // ==================================================
  initial begin
    int          fd;
    int          n;
    int          step;
    string       line;
    logic [31:0] vIns, vAf, vRes, vStall, vFlush, vDec, vAluCtl;
    logic [31:0] vE, vM, vMask, vW, vFlags, vPend;
    logic [3:0]  heldAf;
    logic [31:0] heldRes;

    errCount   = 0;
    checkCount = 0;
    arstN      = 1'b0;
    instrD     = '0;
    aluFlagsE  = '0;
    aluResultE = '0;
    stallE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushE     = 1'b0;
    flushM     = 1'b0;
    flushW     = 1'b0;
    heldAf     = '0;
    heldRes    = '0;
    step       = 0;
    for (int i = 0; i < MaxSlots; i++) begin
      expAluCtl[i] = '0;             // Reset state until the first push lands
      expEBits[i]  = '0;
      expMBits[i]  = '0;
      expMask[i]   = '0;
      expWBits[i]  = '0;
      expFlags[i]  = '0;
    end

    fd = $fopen("armCtrlGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open armCtrlGolden.txt for reading");
      errCount++;
    end else begin
      repeat (8) @(posedge clk);     // Reset held for 8 cycles
      #1 arstN = 1'b1;
      while (!$feof(fd) && step < MaxSlots - 5) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    vIns, vAf, vRes, vStall, vFlush, vDec, vAluCtl,
                    vE, vM, vMask, vW, vFlags, vPend);
        if (n == 13) begin           // Comment and blank lines skip
          @(posedge clk);
          #1;
          instrD     = instrU'(vIns);
          aluFlagsE  = flagsT'(heldAf);  // ALU side follows the word now in E
          aluResultE = heldRes;
          stallE     = vStall[0];
          stallM     = vStall[1];
          stallW     = vStall[2];
          flushE     = vFlush[0];
          flushM     = vFlush[1];
          flushW     = vFlush[2];
          #7;                        // Sample late in the cycle
          checkField("decOut", 32'(decOut), {27'd0, vDec[4:0]});
          checkField("pcWrPendingF", 32'(pcWrPendingF), {31'd0, vPend[0]});
          checkField("aluControlE", 32'(aluControlE), 32'(expAluCtl[step]));
          checkField("aluSrcE", 32'(aluSrcE), 32'(expEBits[step][2]));
          checkField("branchTakenE", 32'(branchTakenE), 32'(expEBits[step][1]));
          checkField("memReadE", 32'(memReadE), 32'(expEBits[step][0]));
          checkField("memWriteM", 32'(memWriteM), 32'(expMBits[step][2]));
          checkField("memReadM", 32'(memReadM), 32'(expMBits[step][1]));
          checkField("regWriteM", 32'(regWriteM), 32'(expMBits[step][0]));
          checkField("byteMaskM", 32'(byteMaskM), 32'(expMask[step]));
          checkField("regWriteW", 32'(regWriteW), 32'(expWBits[step][2]));
          checkField("memReadW", 32'(memReadW), 32'(expWBits[step][1]));
          checkField("pcSrcW", 32'(pcSrcW), 32'(expWBits[step][0]));
          checkField("flags", 32'(flags), 32'(expFlags[step]));
          // A stalled word is not captured so the pipeline step holds
          if (vStall[2:0] == 3'd0) begin
            expAluCtl[step+1] = vAluCtl[3:0];
            expEBits[step+1]  = vE[2:0];
            expMBits[step+2]  = vM[2:0];
            expMask[step+2]   = vMask[3:0];
            expWBits[step+3]  = vW[2:0];
            expFlags[step+4]  = vFlags[3:0];
            heldAf            = vAf[3:0];
            heldRes           = vRes;
            step++;
          end
        end
      end
      $fclose(fd);
    end

    $display("Checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== writebackStage.sv ====
`include "armCtrlSettings.svh"

module writebackStage (
  input  logic               clk,
  input  logic               arstN,
  input  armPipePkg::wbCtrlT wbCtrlM,
  input  logic               stallW,
  input  logic               flushW,
  output logic               regWriteW,
  output logic               memReadW,
  output logic               pcSrcW,
  output logic               wbSetFlagsW,
  output armPipePkg::flagsT  wbFlagsW,
  output armPipePkg::flagsT  flags
);
  import armPipePkg::*;

  wbCtrlT                 wbCtrlW;
  logic [`ARM_NFLAGS-1:0] nzcvQ;   // NZCV field of the status register

  // M to W register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbCtrlW <= '0;
    end else if (!stallW) begin
      if (flushW) wbCtrlW <= '0;
      else        wbCtrlW <= wbCtrlM;
    end
  end

  // Commit once W moves on
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)                                nzcvQ <= '0;
    else if (wbCtrlW.setFlags && !stallW) nzcvQ <= wbCtrlW.flagsNext;
  end

  assign regWriteW   = wbCtrlW.regWrite;
  assign memReadW    = wbCtrlW.memRead;
  assign pcSrcW      = wbCtrlW.pcSrc;
  assign wbSetFlagsW = wbCtrlW.setFlags;
  assign wbFlagsW    = wbCtrlW.flagsNext;
  assign flags       = flagsT'(nzcvQ);

endmodule
